//--- Makefile
VERILATOR ?= verilator
TOP       ?= jsonUartTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A missing pass line also counts as failure, e.g. after an assertion stop
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/byteStreamIf.sv
`timescale 1ns/1ns
`default_nettype none

interface byteStreamIf;

    logic [7:0] data;  // Byte payload
    logic       valid; // Held until accepted
    logic       ready; // Sink can take a byte
    logic       last;  // Final byte of a frame

    modport source (output data, output valid, output last, input ready);

    modport sink (input data, input valid, input last, output ready);

endinterface

`default_nettype wire

//--- hw/jsonComposer.sv
`timescale 1ns/1ns
`default_nettype none

module jsonComposer (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire jsonLinkPkg::cmdWord_u cmd,
    input  wire logic                  sendReq,
    output logic                       busy,
    output logic                       frameDone,
    byteStreamIf.source                out
);

    logic [4:0]                      idx;      // Current byte slot
    logic [4:0]                      nextIdx;
    logic                            fire;     // Byte taken this cycle
    logic                            start;    // Request accepted
    logic [3:0]                      typeDigit;
    logic                            leftNeg;
    logic                            rightNeg;
    logic [jsonLinkPkg::magWidth-1:0] leftMag;
    logic [jsonLinkPkg::magWidth-1:0] rightMag;
    logic [jsonLinkPkg::magWidth-1:0] selMag;  // Wheel being printed
    logic [3:0]                      tensDigit;
    logic [3:0]                      onesDigit;

    // Magnitude after clamping to the print range
    function automatic logic [jsonLinkPkg::magWidth-1:0] clampMag(
        input logic signed [jsonLinkPkg::valWidth-1:0] v
    );
        logic signed [jsonLinkPkg::valWidth:0] mag; // Extra bit so -128 fits
        mag = (v < 0) ? -v : v;
        if (mag > (jsonLinkPkg::valWidth+1)'(jsonLinkPkg::valueLimit)) begin
            mag = (jsonLinkPkg::valWidth+1)'(jsonLinkPkg::valueLimit);
        end
        return mag[jsonLinkPkg::magWidth-1:0];
    endfunction

    assign start     = sendReq && !busy; // Ignored mid-frame
    assign out.valid = busy;             // First byte valid with busy
    assign fire      = out.valid && out.ready;
    assign out.last  = (idx == jsonLinkPkg::slotLast);

    // Skip a sign slot when that wheel is not negative
    always_comb begin
        nextIdx = idx + 5'd1;
        if ((nextIdx == jsonLinkPkg::slotSignL && !leftNeg) ||
            (nextIdx == jsonLinkPkg::slotSignR && !rightNeg)) begin
            nextIdx = idx + 5'd2;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            frameDone <= 1'b0;
            idx       <= 5'd0;
        end else begin
            frameDone <= fire && out.last; // Pulse after the newline goes
            if (start) begin
                busy <= 1'b1;
                idx  <= 5'd0;
            end else if (fire) begin
                if (out.last) begin
                    busy <= 1'b0;
                end
                idx <= nextIdx; // Stalls while ready is low
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            typeDigit <= cmd.fields.cmdType % 4'd10; // 10..15 wrap to 0..5
            leftNeg   <= cmd.fields.leftVal < 0;
            rightNeg  <= cmd.fields.rightVal < 0;
            leftMag   <= clampMag(cmd.fields.leftVal);
            rightMag  <= clampMag(cmd.fields.rightVal);
        end
    end

    assign selMag    = (idx < jsonLinkPkg::slotSignR) ? leftMag : rightMag;
    assign tensDigit = 4'(selMag / 10);
    assign onesDigit = 4'(selMag % 10);

    always_comb begin
        case (idx)
            5'd0:                        out.data = 8'h7B; // '{'
            5'd1, 5'd3, 5'd7, 5'd9,
            5'd17, 5'd19:                out.data = 8'h22; // '"'
            5'd2:                        out.data = 8'h54; // 'T'
            5'd4, 5'd10, 5'd20:          out.data = 8'h3A; // ':'
            5'd5:                        out.data = 8'h30 + {4'd0, typeDigit};
            5'd6, 5'd16:                 out.data = 8'h2C; // ','
            5'd8:                        out.data = 8'h4C; // 'L'
            5'd18:                       out.data = 8'h52; // 'R'
            jsonLinkPkg::slotSignL,
            jsonLinkPkg::slotSignR:      out.data = 8'h2D; // '-'
            5'd12, 5'd22:                out.data = 8'h30; // Leading '0'
            5'd13, 5'd23:                out.data = 8'h2E; // '.'
            5'd14, 5'd24:                out.data = 8'h30 + {4'd0, tensDigit};
            5'd15, 5'd25:                out.data = 8'h30 + {4'd0, onesDigit};
            5'd26:                       out.data = 8'h7D; // '}'
            default:                     out.data = 8'h0A; // Newline slot
        endcase
    end

endmodule

`default_nettype wire

//--- hw/jsonLinkPkg.sv
`default_nettype none

package jsonLinkPkg;

    // Register map, byte addresses on the AXI4-Lite port
    localparam logic [3:0] addrCmd    = 4'h0; // Command word, read/write
    localparam logic [3:0] addrCtrl   = 4'h4; // Bit 0 requests a send
    localparam logic [3:0] addrStatus = 4'h8; // Busy, done, frame count
    localparam logic [3:0] addrBaud   = 4'hC; // Clocks per bit

    localparam logic [1:0]  respOkay     = 2'b00;   // Only response ever given
    localparam logic [15:0] baudResetDiv = 16'd434; // 115200 baud from 50 MHz

    localparam int spareWidth = 12;
    localparam int typeWidth  = 4;
    localparam int valWidth   = 8; // Signed hundredths
    localparam int magWidth   = 7; // Holds 0..99

    localparam int valueLimit = 99; // Clamp, prints as 0.99

    // Byte slots of the longest frame, both signs present
    localparam logic [4:0] slotSignL = 5'd11;
    localparam logic [4:0] slotSignR = 5'd21;
    localparam logic [4:0] slotLast  = 5'd27; // Newline

    typedef struct packed {
        logic [spareWidth-1:0]      spare;    // Ignored
        logic [typeWidth-1:0]       cmdType;  // Printed modulo 10
        logic signed [valWidth-1:0] leftVal;
        logic signed [valWidth-1:0] rightVal;
    } cmdFields_t;

    // Written raw over the bus, read as fields by the composer
    typedef union packed {
        logic [31:0] raw;
        cmdFields_t  fields;
    } cmdWord_u;

endpackage

`default_nettype wire

//--- hw/jsonUartTop.sv
`timescale 1ns/1ns
`default_nettype none

module jsonUartTop (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [3:0]  awaddr,
    input  wire logic        awvalid,
    output logic             awready,
    input  wire logic [31:0] wdata,
    input  wire logic [3:0]  wstrb,
    input  wire logic        wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  wire logic        bready,
    input  wire logic [3:0]  araddr,
    input  wire logic        arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  wire logic        rready,
    output logic             txd,
    output logic             busy
);

    jsonLinkPkg::cmdWord_u cmd;       // Latched by the composer on send
    logic                  sendReq;
    logic [15:0]           baudDiv;
    logic                  frameDone;

    byteStreamIf stream ();           // Composer to transmitter

    linkRegs regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cmd(cmd), .sendReq(sendReq), .baudDiv(baudDiv),
        .busy(busy), .frameDone(frameDone)
    );

    jsonComposer composer (
        .clk(clk), .rst(rst),
        .cmd(cmd), .sendReq(sendReq),
        .busy(busy), .frameDone(frameDone),
        .out(stream.source)
    );

    uartTx tx (
        .clk(clk), .rst(rst),
        .baudDiv(baudDiv),
        .in(stream.sink),
        .txd(txd)
    );

endmodule

`default_nettype wire

//--- hw/linkRegs.sv
`timescale 1ns/1ns
`default_nettype none

module linkRegs (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [3:0]            awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [31:0]           wdata,
    input  wire logic [3:0]            wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [3:0]            araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    output jsonLinkPkg::cmdWord_u      cmd,
    output logic                       sendReq,
    output logic [15:0]                baudDiv,
    input  wire logic                  busy,
    input  wire logic                  frameDone
);

    logic        wrFire;     // Address and data taken together
    logic        rdFire;
    logic        done;       // Sticky until the next accepted send
    logic [7:0]  frameCount; // Completed frames, wraps
    logic [31:0] readWord;

    // Both write channels must be present, and no response outstanding
    assign wrFire  = awvalid && wvalid && !bvalid;
    assign awready = wrFire;
    assign wready  = wrFire;
    assign bresp   = jsonLinkPkg::respOkay;

    assign arready = !rvalid; // One read in flight at most
    assign rdFire  = arvalid && arready;
    assign rresp   = jsonLinkPkg::respOkay;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid  <= 1'b0;
            sendReq <= 1'b0;
            cmd     <= '0;
            baudDiv <= jsonLinkPkg::baudResetDiv;
        end else begin
            // Pulse in the cycle after the CTRL write
            sendReq <= wrFire && (awaddr == jsonLinkPkg::addrCtrl) && wstrb[0] && wdata[0];
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0; // Response accepted
            end
            if (wrFire && (awaddr == jsonLinkPkg::addrCmd)) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[i]) begin
                        cmd.raw[8*i +: 8] <= wdata[8*i +: 8]; // Per-byte strobe
                    end
                end
            end
            if (wrFire && (awaddr == jsonLinkPkg::addrBaud)) begin
                for (int i = 0; i < 2; i++) begin
                    if (wstrb[i]) begin
                        baudDiv[8*i +: 8] <= wdata[8*i +: 8]; // Upper strobes unused
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done       <= 1'b0;
            frameCount <= 8'd0;
        end else begin
            if (sendReq && !busy) begin
                done <= 1'b0; // Only an accepted request clears it
            end else if (frameDone) begin
                done <= 1'b1;
            end
            if (frameDone) begin
                frameCount <= frameCount + 8'd1;
            end
        end
    end

    always_comb begin
        case (araddr)
            jsonLinkPkg::addrCmd:    readWord = cmd.raw;
            jsonLinkPkg::addrStatus: readWord = {16'd0, frameCount, 6'd0, done, busy};
            jsonLinkPkg::addrBaud:   readWord = {16'd0, baudDiv};
            default:                 readWord = 32'd0; // CTRL and holes read zero
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rdFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rdata <= readWord; // Captured at the address handshake
        end
    end

endmodule

`default_nettype wire

//--- hw/uartTx.sv
`timescale 1ns/1ns
`default_nettype none

module uartTx (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic [15:0] baudDiv,
    byteStreamIf.sink        in,
    output logic             txd
);

    logic        active;    // Frame on the line
    logic [9:0]  shiftReg;  // Stop, data, start, LSB goes out first
    logic [3:0]  bitCnt;    // Bit being sent, 0..9
    logic [15:0] periodCnt; // Clocks into the current bit
    logic [15:0] bitLen;    // Divider taken with the byte
    logic        bitEnd;

    assign in.ready = !active;          // Idle means ready
    assign bitEnd   = (periodCnt == bitLen - 16'd1);
    assign txd      = shiftReg[0];      // Straight from a flop

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            shiftReg  <= '1;            // Line idles high
            bitCnt    <= 4'd0;
            periodCnt <= 16'd0;
        end else if (!active) begin
            if (in.valid) begin
                active    <= 1'b1;
                shiftReg  <= {1'b1, in.data, 1'b0}; // Start bit next cycle
                bitCnt    <= 4'd0;
                periodCnt <= 16'd0;
            end
        end else if (bitEnd) begin
            periodCnt <= 16'd0;
            shiftReg  <= {1'b1, shiftReg[9:1]};     // Fill with idle level
            if (bitCnt == 4'd9) begin
                active <= 1'b0;                     // Stop bit done
            end else begin
                bitCnt <= bitCnt + 4'd1;
            end
        end else begin
            periodCnt <= periodCnt + 16'd1;
        end
    end

    // A divider change only affects the next byte
    always_ff @(posedge clk) begin
        if (!active && in.valid) begin
            bitLen <= baudDiv;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hw/jsonLinkPkg.sv
hw/byteStreamIf.sv
hw/linkRegs.sv
hw/jsonComposer.sv
hw/uartTx.sv
hw/jsonUartTop.sv
testbench/jsonUart_chk.sv
testbench/jsonUartTb.sv

//--- testbench/jsonUartTb.sv
`timescale 1ns/1ns
`default_nettype none

module jsonUartTb;

    localparam int framesSent = 12; // Frames over tests 3 to 6
    localparam int maxDiv     = 13; // Slowest divider used
    localparam longint watchdogNs = longint'(framesSent) * 28 * 10 * maxDiv * 40 + 400_000;

    logic        clk = 1'b0;
    logic        rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        txd;
    logic        busy;

    int          errors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          bitDiv = jsonLinkPkg::baudResetDiv; // Receiver's idea of the bit period
    integer      seed = 32'hc22c_85a5;
    logic [7:0]  rxQ[$];                              // Decoded serial bytes

    jsonUartTop dut_i (.*);

    always #20 clk = ~clk; // 25 MHz

    // Serial receiver sampling near mid-bit on falling clock edges
    initial begin : uartRx
        logic [7:0] rxByte;
        int         div;
        forever begin
            @(negedge txd);
            div = bitDiv;
            repeat (div / 2) @(negedge clk);
            assert (!txd) else begin
                $display("Receiver error at %0t: start bit ended early", $time);
                errors++;
            end
            for (int i = 0; i < 8; i++) begin
                repeat (div) @(negedge clk);
                rxByte[i] = txd; // LSB first
            end
            repeat (div) @(negedge clk);
            assert (txd) else begin
                $display("Receiver error at %0t: stop bit was low", $time);
                errors++;
            end
            rxQ.push_back(rxByte);
        end
    end

    // Clamped wheel text with optional sign and 0.dd
    function automatic string fmtWheel(input logic signed [7:0] v);
        int    mag;
        string sign;
        sign = "";
        mag  = int'(v);
        if (mag < 0) begin
            sign = "-";
            mag  = -mag;
        end
        if (mag > jsonLinkPkg::valueLimit) begin
            mag = jsonLinkPkg::valueLimit;
        end
        return $sformatf("%s0.%0d%0d", sign, mag / 10, mag % 10);
    endfunction

    // Expected line without its newline
    function automatic string refLine(input logic [31:0] w);
        return $sformatf("{\"T\":%0d,\"L\":%s,\"R\":%s}", w[19:16] % 10,
                         fmtWheel(w[15:8]), fmtWheel(w[7:0]));
    endfunction

    function automatic logic [31:0] makeCmd(input int t, input int l, input int r);
        return {12'h000, 4'(t), 8'(l), 8'(r)}; // Spare, type, left, right
    endfunction

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clk); while (!(awready && wready)); // Both taken on the next rising edge
        @(posedge clk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        do @(negedge clk); while (!bvalid);
        @(posedge clk);
        #2;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        #2;
        arvalid = 1'b0;
        rready  = 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata; // Stable until the rready edge
        @(posedge clk);
        #2;
        rready = 1'b0;
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Returns the text before the next newline
    task automatic recvLine(output string s);
        s = "";
        while (rxQ.size() == 0 || rxQ[$] != 8'h0A) @(negedge clk);
        while (rxQ.size() > 1) s = $sformatf("%s%c", s, rxQ.pop_front());
        void'(rxQ.pop_front()); // Newline itself
    endtask

    task automatic sendCommand(input logic [31:0] w);
        axiWrite(jsonLinkPkg::addrCmd, w, 4'hF);
        axiWrite(jsonLinkPkg::addrCtrl, 32'd1, 4'h1);
    endtask

    task automatic expectLine(input logic [31:0] w);
        string got;
        recvLine(got);
        assert (got == refLine(w)) else begin
            $display("Fail %0t: received %s, expected %s", $time, got, refLine(w));
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errors != errBefore) begin
            testsFailed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    task automatic resetState();
        logic [31:0] v;
        int          e0;
        e0 = errors;
        axiRead(jsonLinkPkg::addrStatus, v);
        checkValue("STATUS", v, 32'd0);
        axiRead(jsonLinkPkg::addrBaud, v);
        checkValue("BAUD", v, {16'd0, jsonLinkPkg::baudResetDiv});
        checkValue("txd", {31'd0, txd}, 32'd1);
        checkValue("busy pin", {31'd0, busy}, 32'd0);
        checkValue("bytes seen", rxQ.size(), 32'd0);
        reportTest("reset state", e0);
    endtask

    task automatic registerReadback();
        logic [31:0] v;
        int          e0;
        e0 = errors;
        axiWrite(jsonLinkPkg::addrCmd, 32'h1234_5678, 4'hF);
        axiWrite(jsonLinkPkg::addrCmd, 32'hAABB_CCDD, 4'b0101); // Bytes 0 and 2 only
        axiRead(jsonLinkPkg::addrCmd, v);
        checkValue("CMD", v, 32'h12BB_56DD);
        axiWrite(jsonLinkPkg::addrBaud, 32'h0000_1234, 4'hF);
        axiWrite(jsonLinkPkg::addrBaud, 32'hFFFF_FF08, 4'b0001);
        axiWrite(jsonLinkPkg::addrBaud, 32'h0000_0000, 4'b0010);
        axiRead(jsonLinkPkg::addrBaud, v);
        checkValue("BAUD", v, 32'h0000_0008);
        bitDiv = 8;
        axiRead(jsonLinkPkg::addrCtrl, v);
        checkValue("CTRL", v, 32'd0);
        reportTest("register readback", e0);
    endtask

    task automatic frameFormatting();
        logic [31:0] cmds[4];
        int          e0;
        e0 = errors;
        cmds = '{makeCmd(1, 50, -25), makeCmd(0, 0, 0), makeCmd(9, -25, 25),
                 makeCmd(7, -1, -10)};
        foreach (cmds[i]) begin
            sendCommand(cmds[i]);
            expectLine(cmds[i]);
        end
        reportTest("frame formatting", e0);
    endtask

    task automatic clampAndRandom();
        logic [31:0] w;
        int          e0;
        e0 = errors;
        sendCommand(makeCmd(3, 127, -128));
        expectLine(makeCmd(3, 127, -128));
        sendCommand(makeCmd(12, 100, -100)); // Type wraps to 2
        expectLine(makeCmd(12, 100, -100));
        repeat (4) begin
            w = $random(seed); // Spare bits random too
            sendCommand(w);
            expectLine(w);
        end
        reportTest("clamping and random", e0);
    endtask

    task automatic statusBehavior();
        logic [31:0] v;
        logic [7:0]  f0;
        int          e0;
        e0 = errors;
        axiRead(jsonLinkPkg::addrStatus, v);
        f0 = v[15:8];
        sendCommand(makeCmd(4, -60, 33));
        axiWrite(jsonLinkPkg::addrCtrl, 32'd1, 4'h1); // Lands mid-frame
        axiRead(jsonLinkPkg::addrStatus, v);
        checkValue("busy and done mid-frame", v[1:0], 32'd1);
        checkValue("busy pin mid-frame", {31'd0, busy}, 32'd1);
        expectLine(makeCmd(4, -60, 33));
        repeat (20 * bitDiv) @(negedge clk); // Room for two stray bytes
        checkValue("extra bytes", rxQ.size(), 32'd0);
        axiRead(jsonLinkPkg::addrStatus, v);
        checkValue("busy and done after frame", v[1:0], 32'd2);
        checkValue("busy pin after frame", {31'd0, busy}, 32'd0);
        checkValue("frameCount", v[15:8], 8'(f0 + 8'd1));
        reportTest("status behavior", e0);
    endtask

    task automatic dividerChange();
        logic [31:0] v;
        int          e0;
        e0 = errors;
        axiWrite(jsonLinkPkg::addrBaud, 32'd13, 4'hF);
        axiRead(jsonLinkPkg::addrBaud, v);
        checkValue("BAUD", v, 32'd13);
        bitDiv = 13;
        sendCommand(makeCmd(5, -99, 8));
        expectLine(makeCmd(5, -99, 8));
        reportTest("divider change", e0);
    endtask

    initial begin : mainFlow
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        resetState();
        registerReadback();
        frameFormatting();
        clampAndRandom();
        statusBehavior();
        dividerChange();
        $display("Summary: %0d tests run, %0d failed, %0d check errors",
                 testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Bounded by the worst-case serial time of all frames
    initial begin : watchdog
        #(watchdogNs);
        $display("Timeout: tests did not finish within %0d ns", watchdogNs);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/jsonUart_chk.sv
`timescale 1ns/1ns
`default_nettype none

module jsonUart_chk (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       bvalid,
    input wire logic       bready,
    input wire logic [1:0] bresp,
    input wire logic       rvalid,
    input wire logic       rready,
    input wire logic [1:0] rresp,
    input wire logic       lineIdle, // Transmitter ready, no frame on the line
    input wire logic       txd
);

    bHeld: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHeld: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Idle line sits at the stop level
    idleHigh: assert property (@(posedge clk) disable iff (rst) lineIdle |-> txd)
        else $error("txd low while the transmitter is idle");

    bOkay: assert property (@(posedge clk) disable iff (rst) bvalid |-> bresp == 2'b00)
        else $error("write response carries an error code");

    rOkay: assert property (@(posedge clk) disable iff (rst) rvalid |-> rresp == 2'b00)
        else $error("read response carries an error code");

endmodule

bind jsonUartTop jsonUart_chk chk_i (
    .clk(clk), .rst(rst),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .rvalid(rvalid), .rready(rready), .rresp(rresp),
    .lineIdle(stream.ready), .txd(txd)
);

`default_nettype wire
